// ==== Makefile ====
# Verilator build for the integer execute slice

TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_ex_unit
FILELIST   := project.f
BUILD      := obj_dir
LOG        := sim.log
PASS_MSG   := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== ex_alu_split.sv ====
//////////////////////////////
// two-cycle rv32i alu built on one 17-bit adder
// cycle 1 (req_i high) adds the low halves and stores sum and carry
// cycle 2 (req_i low) adds the high halves and completes result_o and cmp_o
// operands and operator must stay stable over both cycles
// logic and shift results are combinational but read in cycle 2
//////////////////////////////

`default_nettype none

module ex_alu_split
  import ex_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [ALU_OP_WIDTH-1:0] operator_i,
  input  logic [XLEN-1:0]         operand_a_i,
  input  logic [XLEN-1:0]         operand_b_i,
  input  logic                    req_i,
  output logic [XLEN-1:0]         result_o,
  output logic                    cmp_o
);

  //////////////////////////////
  // split adder
  //////////////////////////////

  logic                negate_b;
  logic [XLEN-1:0]     operand_b_x;
  logic [ADD_HALF:0]   adder_in_a;
  logic [ADD_HALF:0]   adder_in_b;
  logic                adder_cin;
  logic [ADD_HALF:0]   adder_sum;
  logic [ADD_HALF:0]   partial_q;
  logic [XLEN-1:0]     adder_result;

  // everything except add works on a - b
  // logic and shift ops ignore the adder, so the difference only feeds the flag
  assign negate_b    = (operator_i != ALU_ADD);
  assign operand_b_x = negate_b ? ~operand_b_i : operand_b_i;

  always_comb
  begin
    if (req_i)
    begin
      // low half takes the +1 of the two's complement as carry in
      adder_in_a = {1'b0, operand_a_i[ADD_HALF-1:0]};
      adder_in_b = {1'b0, operand_b_x[ADD_HALF-1:0]};
      adder_cin  = negate_b;
    end
    else
    begin
      // high half picks up the stored carry
      adder_in_a = {1'b0, operand_a_i[XLEN-1:ADD_HALF]};
      adder_in_b = {1'b0, operand_b_x[XLEN-1:ADD_HALF]};
      adder_cin  = partial_q[ADD_HALF];
    end
  end

  // the one physical adder
  assign adder_sum = adder_in_a + adder_in_b + {{ADD_HALF{1'b0}}, adder_cin};

  // full sum is only meaningful in the second cycle
  assign adder_result = {adder_sum[ADD_HALF-1:0], partial_q[ADD_HALF-1:0]};

  // low sum and carry out of phase one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      partial_q <= '0;
    end
    else if (req_i)
    begin
      partial_q <= adder_sum;
    end
  end

  //////////////////////////////
  // shifter
  //////////////////////////////

  logic                shift_left;
  logic                shift_arith;
  logic [XLEN-1:0]     operand_a_rev;
  logic [XLEN-1:0]     shift_in;
  logic [2*XLEN-1:0]   shift_ext;
  logic [2*XLEN-1:0]   shift_wide;
  logic [XLEN-1:0]     shift_right;
  logic [XLEN-1:0]     shift_right_rev;
  logic [XLEN-1:0]     shift_result;

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // bit reversal turns the right shifter into a left shifter
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      operand_a_rev[i] = operand_a_i[XLEN-1-i];
    end
  end

  // reversed back on the way out
  always_comb
  begin
    for (int i = 0; i < XLEN; i++)
    begin
      shift_right_rev[i] = shift_right[XLEN-1-i];
    end
  end

  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // upper word holds the fill bits that carry the sign only for sra
  assign shift_ext   = {{XLEN{shift_arith & shift_in[XLEN-1]}}, shift_in};
  assign shift_wide  = shift_ext >> operand_b_i[SHAMT_WIDTH-1:0];
  assign shift_right = shift_wide[XLEN-1:0];

  assign shift_result = shift_left ? shift_right_rev : shift_right;

  //////////////////////////////
  // comparator
  //////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_ge;
  logic cmp_result;

  assign cmp_signed = (operator_i == ALU_SLTS) || (operator_i == ALU_LTS) ||
                      (operator_i == ALU_GES);

  // add has no difference on the adder, so it checks equality directly
  assign is_equal = (operator_i == ALU_ADD) ? (operand_a_i == operand_b_i)
                                            : (adder_result == '0);

  // with equal signs the difference cannot overflow and its sign decides
  // with different signs signed ge needs a negative b and unsigned ge the msb of a
  always_comb
  begin
    if (operand_a_i[XLEN-1] == operand_b_i[XLEN-1])
      is_ge = ~adder_result[XLEN-1];
    else
      is_ge = cmp_signed ? operand_b_i[XLEN-1] : operand_a_i[XLEN-1];
  end

  always_comb
  begin
    unique case (operator_i)
      ALU_EQ:                 cmp_result = is_equal;
      ALU_NE:                 cmp_result = ~is_equal;
      ALU_GES, ALU_GEU:       cmp_result = is_ge;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU:     cmp_result = ~is_ge;
      // non-compare ops report a == b
      default:                cmp_result = is_equal;
    endcase
  end

  assign cmp_o = cmp_result;

  //////////////////////////////
  // result mux
  //////////////////////////////

  always_comb
  begin
    unique case (operator_i)
      ALU_ADD, ALU_SUB:           result_o = adder_result;
      ALU_AND:                    result_o = operand_a_i & operand_b_i;
      ALU_OR:                     result_o = operand_a_i | operand_b_i;
      ALU_XOR:                    result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA:  result_o = shift_result;
      // set-less-than and branch conditions land in bit 0
      default:                    result_o = {{(XLEN-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

`default_nettype wire

// ==== ex_cmd_queue.sv ====
//////////////////////////////
// four-entry command fifo, head visible the cycle after the write
// a write into a full queue is dropped, credits keep upstream from it
// credit_o pulses for one cycle after every pop
//////////////////////////////

`default_nettype none

module ex_cmd_queue
  import ex_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_i,
  input  logic [CMD_WIDTH-1:0] wr_data_i,
  input  logic                 rd_i,
  output logic [CMD_WIDTH-1:0] rd_data_o,
  output logic                 not_empty_o,
  output logic                 credit_o
);

  logic [CMD_WIDTH-1:0]     mem_q [CMD_DEPTH];
  logic [CMD_PTR_WIDTH-1:0] wr_ptr_q;
  logic [CMD_PTR_WIDTH-1:0] rd_ptr_q;
  logic [CMD_CNT_WIDTH-1:0] count_q;
  logic                     do_wr;
  logic                     do_rd;

  // guard both ends so pointers never run past each other
  assign do_wr = wr_i && (count_q != CMD_CNT_WIDTH'(CMD_DEPTH));
  assign do_rd = rd_i && not_empty_o;

  assign not_empty_o = (count_q != '0);
  assign rd_data_o   = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem_q[wr_ptr_q] <= wr_data_i;
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_rd)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // simultaneous read and write leaves the count alone
      if (do_wr && !do_rd)
        count_q <= count_q + 1'b1;
      else if (do_rd && !do_wr)
        count_q <= count_q - 1'b1;
      // one credit back upstream per freed entry
      credit_o <= do_rd;
    end
  end

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
//////////////////////////////
// shared constants for the integer execute slice
// operand width is fixed at 32, the split adder relies on an even width
// queue depth equals the upstream credit count after reset
// result credit counter must be wide enough to hold RES_CREDITS
//////////////////////////////

`default_nettype none

package ex_pkg;

  // datapath widths
  localparam int XLEN         = 32;
  localparam int ADD_HALF     = XLEN / 2;
  localparam int SHAMT_WIDTH  = $clog2(XLEN);
  localparam int ALU_OP_WIDTH = 4;

  //////////////////////////////
  // alu operation codes
  //////////////////////////////
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 4'd2;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 4'd4;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 4'd5;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTS = 4'd8;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 4'd9;
  // branch conditions
  localparam logic [ALU_OP_WIDTH-1:0] ALU_EQ   = 4'd10;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_NE   = 4'd11;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_LTS  = 4'd12;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GES  = 4'd13;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_LTU  = 4'd14;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GEU  = 4'd15;

  //////////////////////////////
  // command queue and credits
  //////////////////////////////
  // one entry is {op, a, b}
  localparam int CMD_WIDTH     = ALU_OP_WIDTH + 2 * XLEN;
  localparam int CMD_DEPTH     = 4;
  localparam int CMD_PTR_WIDTH = $clog2(CMD_DEPTH);
  localparam int CMD_CNT_WIDTH = $clog2(CMD_DEPTH + 1);

  // downstream credits held by the sequencer after reset
  localparam int RES_CREDITS   = 2;
  localparam int RES_CNT_WIDTH = 2;

endpackage

`default_nettype wire

// ==== ex_sequencer.sv ====
//////////////////////////////
// drives the two alu phases and the result port
// an operation starts only with a result credit in hand, spent at start
// res_valid_o is a one-cycle pulse, res_credit_i at most one per cycle
// one result per three cycles at best, results stay in queue order
//////////////////////////////

`default_nettype none

module ex_sequencer
  import ex_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            head_valid_i,
  output logic            pop_o,
  output logic            alu_req_o,
  input  logic [XLEN-1:0] alu_result_i,
  input  logic            alu_cmp_i,
  input  logic            res_credit_i,
  output logic            res_valid_o,
  output logic [XLEN-1:0] res_data_o,
  output logic            res_flag_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOW,
    S_HIGH
  } seq_state_e;

  seq_state_e               state_q;
  seq_state_e               state_d;
  logic [RES_CNT_WIDTH-1:0] credit_cnt_q;
  logic                     start;

  //////////////////////////////
  // phase control
  //////////////////////////////

  // head must be present and a downstream slot reserved
  assign start = (state_q == S_IDLE) && head_valid_i && (credit_cnt_q != '0);

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      S_IDLE:  if (start) state_d = S_LOW;
      S_LOW:   state_d = S_HIGH;
      S_HIGH:  state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  // low phase asks the alu for the first add half
  assign alu_req_o = (state_q == S_LOW);
  // high phase is the last cycle the head entry is needed
  assign pop_o     = (state_q == S_HIGH);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= S_IDLE;
      credit_cnt_q <= RES_CNT_WIDTH'(RES_CREDITS);
      res_valid_o  <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      res_valid_o <= (state_q == S_HIGH);
      // spend on start, refill on a returned pulse, both cancel out
      if (start && !res_credit_i)
        credit_cnt_q <= credit_cnt_q - 1'b1;
      else if (res_credit_i && !start)
        credit_cnt_q <= credit_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // result register
  //////////////////////////////

  // captured at the end of the high phase when the alu output is complete
  always_ff @(posedge clk)
  begin
    if (state_q == S_HIGH)
    begin
      res_data_o <= alu_result_i;
      res_flag_o <= alu_cmp_i;
    end
  end

endmodule

`default_nettype wire

// ==== ex_unit_checker.sv ====
//////////////////////////////
// watches the execute slice ports and compares every result
// expected values follow rv32i rules, results in command order
// all ports sampled on the rising edge
//////////////////////////////

`default_nettype none

module ex_unit_checker
  import ex_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid_i,
  input  logic [ALU_OP_WIDTH-1:0] cmd_op_i,
  input  logic [XLEN-1:0]         cmd_a_i,
  input  logic [XLEN-1:0]         cmd_b_i,
  input  logic                    cmd_credit_i,
  input  logic                    res_credit_i,
  input  logic                    res_valid_i,
  input  logic [XLEN-1:0]         res_data_i,
  input  logic                    res_flag_i,
  output int                      data_errs_o,
  output int                      flag_errs_o,
  output int                      proto_errs_o,
  output int                      res_count_o,
  output int                      credit_count_o
);

  logic [CMD_WIDTH-1:0] expect_q [$];
  int                   cmd_count;
  int                   down_returned;

  // reference model, returns {flag, data}
  function automatic logic [XLEN:0] model(input logic [ALU_OP_WIDTH-1:0] op,
                                          input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
    logic [XLEN-1:0] d;
    logic            f;
    d = '0;
    f = (a == b);
    case (op)
      ALU_ADD: d = a + b;
      ALU_SUB: d = a - b;
      ALU_AND: d = a & b;
      ALU_OR:  d = a | b;
      ALU_XOR: d = a ^ b;
      ALU_SLL: d = a << b[4:0];
      ALU_SRL: d = a >> b[4:0];
      ALU_SRA: d = $signed(a) >>> b[4:0];
      ALU_SLTS, ALU_LTS: d[0] = ($signed(a) < $signed(b));
      ALU_SLTU, ALU_LTU: d[0] = (a < b);
      ALU_EQ:  d[0] = (a == b);
      ALU_NE:  d[0] = (a != b);
      ALU_GES: d[0] = ($signed(a) >= $signed(b));
      ALU_GEU: d[0] = (a >= b);
      default: d = '0;
    endcase
    // compare ops report their own outcome as the flag
    if (op inside {ALU_SLTS, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LTS, ALU_GES, ALU_LTU, ALU_GEU})
      f = d[0];
    return {f, d};
  endfunction

  always @(posedge clk)
  begin
    logic [CMD_WIDTH-1:0]    cmd;
    logic [XLEN:0]           exp;
    logic [ALU_OP_WIDTH-1:0] op;
    logic [XLEN-1:0]         a;
    logic [XLEN-1:0]         b;
    if (rst_n)
    begin
      if (cmd_credit_i)
        credit_count_o++;
      if (res_credit_i)
        down_returned++;
      if (res_valid_i)
      begin
        res_count_o++;
        if (expect_q.size() == 0)
        begin
          proto_errs_o++;
          $display("result appeared with no command pending at t=%0t", $time);
        end
        else
        begin
          cmd = expect_q.pop_front();
          {op, a, b} = cmd;
          exp = model(op, a, b);
          if (res_data_i !== exp[XLEN-1:0])
          begin
            data_errs_o++;
            $display("FAIL t=%0t res_data_o op=%0d exp=%h got=%h",
                     $time, op, exp[XLEN-1:0], res_data_i);
          end
          if (res_flag_i !== exp[XLEN])
          begin
            flag_errs_o++;
            $display("FAIL t=%0t res_flag_o op=%0d exp=%b got=%b",
                     $time, op, exp[XLEN], res_flag_i);
          end
        end
        // every result must be covered by a downstream credit
        if (res_count_o - down_returned > RES_CREDITS)
        begin
          proto_errs_o++;
          $display("result sent without a downstream credit at t=%0t", $time);
        end
      end
      if (cmd_valid_i)
      begin
        expect_q.push_back({cmd_op_i, cmd_a_i, cmd_b_i});
        cmd_count++;
        // credits lag the pop, so this bounds the real occupancy
        if (cmd_count - credit_count_o > CMD_DEPTH)
        begin
          proto_errs_o++;
          $display("command written into a full queue at t=%0t", $time);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ex_unit_props.sv ====
//////////////////////////////
// sequencer properties bound into every ex_sequencer
// credit bound assumes downstream never returns more than it was given
//////////////////////////////

`default_nettype none

module ex_unit_props
  import ex_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     alu_req_i,
  input  logic                     res_valid_i,
  input  logic [RES_CNT_WIDTH-1:0] credit_cnt_i
);

  // phase one lasts a single cycle
  req_single: assert property (@(posedge clk) disable iff (!rst_n)
    alu_req_i |=> !alu_req_i)
    else $error("alu request stayed high for two cycles");

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt_i <= RES_CNT_WIDTH'(RES_CREDITS))
    else $error("result credit counter above its reset value");

  valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_i |=> !res_valid_i)
    else $error("res_valid_o lasted longer than one cycle");

  // the start cycle before phase one must have held a credit
  start_credit: assert property (@(posedge clk) disable iff (!rst_n)
    alu_req_i |-> ($past(credit_cnt_i) != '0))
    else $error("operation started without a result credit");

endmodule

bind ex_sequencer ex_unit_props i_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .alu_req_i    (alu_req_o),
  .res_valid_i  (res_valid_o),
  .credit_cnt_i (credit_cnt_q)
);

`default_nettype wire

// ==== ex_unit_top.sv ====
//////////////////////////////
// integer execute slice, credit flow control on both sides
// upstream starts with CMD_DEPTH credits, one back per cmd_credit_o pulse
// result 3 cycles after the command edge when idle and a credit is free
//////////////////////////////

`default_nettype none

module ex_unit_top
  import ex_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid_i,
  input  logic [ALU_OP_WIDTH-1:0] cmd_op_i,
  input  logic [XLEN-1:0]         cmd_a_i,
  input  logic [XLEN-1:0]         cmd_b_i,
  output logic                    cmd_credit_o,
  input  logic                    res_credit_i,
  output logic                    res_valid_o,
  output logic [XLEN-1:0]         res_data_o,
  output logic                    res_flag_o
);

  logic [CMD_WIDTH-1:0]    head_data;
  logic                    head_valid;
  logic                    pop;
  logic                    alu_req;
  logic [XLEN-1:0]         alu_result;
  logic                    alu_cmp;
  logic [ALU_OP_WIDTH-1:0] head_op;
  logic [XLEN-1:0]         head_a;
  logic [XLEN-1:0]         head_b;

  // entry layout {op, a, b}
  assign {head_op, head_a, head_b} = head_data;

  ex_cmd_queue i_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (cmd_valid_i),
    .wr_data_i   ({cmd_op_i, cmd_a_i, cmd_b_i}),
    .rd_i        (pop),
    .rd_data_o   (head_data),
    .not_empty_o (head_valid),
    .credit_o    (cmd_credit_o)
  );

  ex_sequencer i_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .alu_req_o    (alu_req),
    .alu_result_i (alu_result),
    .alu_cmp_i    (alu_cmp),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_data_o   (res_data_o),
    .res_flag_o   (res_flag_o)
  );

  // head fields hold until the pop, so operands are stable over both phases
  ex_alu_split i_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .operator_i  (head_op),
    .operand_a_i (head_a),
    .operand_b_i (head_b),
    .req_i       (alu_req),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

endmodule

`default_nettype wire

// ==== project.f ====
ex_pkg.sv
ex_alu_split.sv
ex_cmd_queue.sv
ex_sequencer.sv
ex_unit_top.sv
ex_unit_props.sv
ex_unit_checker.sv
tb_ex_unit.sv

// ==== tb_ex_unit.sv ====
//////////////////////////////
// testbench for the execute slice, lcg stimulus from a fixed seed
// inputs change on the falling edge, ports checked in ex_unit_checker
// first phase holds result credits back, then free-running traffic
//////////////////////////////

`default_nettype none

module tb_ex_unit
  import ex_pkg::*;
();

  localparam logic [31:0] SEED       = 32'h5d86;
  localparam int          NUM_CMDS   = 400;
  localparam int          WAIT_LIMIT = 600;

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_valid;
  logic [ALU_OP_WIDTH-1:0] cmd_op;
  logic [XLEN-1:0]         cmd_a;
  logic [XLEN-1:0]         cmd_b;
  logic                    cmd_credit;
  logic                    res_credit;
  logic                    res_valid;
  logic [XLEN-1:0]         res_data;
  logic                    res_flag;
  logic                    hold_credits;
  logic [31:0]             stim_state;
  logic [31:0]             credit_state;
  int                      sent;
  int                      up_returned;
  int                      down_returned;
  int                      timeout_errs;
  int                      count_errs;
  int                      data_errs;
  int                      flag_errs;
  int                      proto_errs;
  int                      res_count;
  int                      credit_count;

  ex_unit_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_op_i     (cmd_op),
    .cmd_a_i      (cmd_a),
    .cmd_b_i      (cmd_b),
    .cmd_credit_o (cmd_credit),
    .res_credit_i (res_credit),
    .res_valid_o  (res_valid),
    .res_data_o   (res_data),
    .res_flag_o   (res_flag)
  );

  ex_unit_checker i_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_op_i       (cmd_op),
    .cmd_a_i        (cmd_a),
    .cmd_b_i        (cmd_b),
    .cmd_credit_i   (cmd_credit),
    .res_credit_i   (res_credit),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_flag_i     (res_flag),
    .data_errs_o    (data_errs),
    .flag_errs_o    (flag_errs),
    .proto_errs_o   (proto_errs),
    .res_count_o    (res_count),
    .credit_count_o (credit_count)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // corner values first, the rest scrambled from the lcg word
  function automatic logic [31:0] shape_operand(input logic [31:0] r);
    case (r[31:29])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h0000_ffff;
      default: return r ^ {r[15:0], r[31:16]};
    endcase
  endfunction

  // upstream credits come back one per pulse
  always @(posedge clk)
  begin
    if (rst_n && cmd_credit)
      up_returned++;
  end

  //////////////////////////////
  // upstream agent
  //////////////////////////////

  task automatic send_command();
    int gap;
    int waited;
    stim_state = lcg_next(stim_state);
    gap        = int'(stim_state[31:30]);
    cmd_op     = stim_state[27:24];
    stim_state = lcg_next(stim_state);
    cmd_a      = shape_operand(stim_state);
    stim_state = lcg_next(stim_state);
    cmd_b      = shape_operand(stim_state);
    stim_state = lcg_next(stim_state);
    if (stim_state[31:29] == 3'd0)
      cmd_b = cmd_a;
    repeat (gap) @(negedge clk);
    waited = 0;
    while ((sent - up_returned >= CMD_DEPTH) && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (sent - up_returned >= CMD_DEPTH)
    begin
      timeout_errs++;
      $display("upstream waited too long for a command credit at t=%0t", $time);
      return;
    end
    cmd_valid = 1'b1;
    sent++;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_for_results(input int target);
    int waited;
    waited = 0;
    while ((res_count < target) && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (res_count < target)
    begin
      timeout_errs++;
      $display("timed out waiting for %0d results, only %0d seen", target, res_count);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (exp != got)
    begin
      count_errs++;
      $display("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
    end
  endtask

  task automatic report_and_finish();
    int total;
    total = data_errs + flag_errs + proto_errs + timeout_errs + count_errs;
    $display("errors: data %0d, flag %0d, protocol %0d, timeout %0d, count %0d",
             data_errs, flag_errs, proto_errs, timeout_errs, count_errs);
    if (total == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  //////////////////////////////
  // downstream agent
  //////////////////////////////

  initial
  begin
    int delay;
    res_credit    = 1'b0;
    credit_state  = ~SEED;
    down_returned = 0;
    delay         = 0;
    forever
    begin
      @(negedge clk);
      res_credit = 1'b0;
      if (delay > 0)
        delay--;
      else if (rst_n && !hold_credits && (res_count > down_returned))
      begin
        res_credit    = 1'b1;
        down_returned++;
        credit_state  = lcg_next(credit_state);
        delay         = int'(credit_state[31:29]);
      end
    end
  end

  // main sequence
  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = '0;
    cmd_a        = '0;
    cmd_b        = '0;
    hold_credits = 1'b1;
    stim_state   = SEED;
    sent         = 0;
    up_returned  = 0;
    timeout_errs = 0;
    count_errs   = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // no credits returned yet, only the reset credits may produce results
    for (int i = 0; i < CMD_DEPTH; i++)
      send_command();
    wait_for_results(RES_CREDITS);
    repeat (12) @(negedge clk);
    check_count("results before any credit return", RES_CREDITS, res_count);
    @(posedge clk);
    hold_credits = 1'b0;
    @(negedge clk);
    for (int i = 0; (i < NUM_CMDS) && (timeout_errs == 0); i++)
      send_command();
    wait_for_results(sent);
    repeat (4) @(negedge clk);
    check_count("result count", sent, res_count);
    check_count("cmd_credit_o pulses", sent, credit_count);
    report_and_finish();
  end

endmodule

`default_nettype wire
